/* common/nand_cmd_pkg.sv */
`default_nettype none

package nand_cmd_pkg;

    // SPI NAND opcodes
    localparam logic [7:0] OP_RESET         = 8'hFF;
    localparam logic [7:0] OP_WRITE_ENABLE  = 8'h06;
    localparam logic [7:0] OP_WRITE_DISABLE = 8'h04;
    localparam logic [7:0] OP_GET_FEATURE   = 8'h0F;    // Opcode, feature addr, MISO data
    localparam logic [7:0] OP_SET_FEATURE   = 8'h1F;    // Opcode, feature addr, MOSI data
    localparam logic [7:0] OP_PAGE_READ     = 8'h13;    // Opcode, 24-bit row address
    localparam logic [7:0] OP_PROG_EXEC     = 8'h10;
    localparam logic [7:0] OP_BLOCK_ERASE   = 8'hD8;

    // SCLK = i_Clk / (2 x CLKS_PER_HALF_BIT), so one byte is 64 clocks
    localparam int CLKS_PER_HALF_BIT = 4;
    localparam int HALF_CNT_W        = $clog2(CLKS_PER_HALF_BIT);

    // CS high time after a frame before the next one may start
    localparam int CS_GAP_CLKS = 8;
    localparam int GAP_CNT_W   = $clog2(CS_GAP_CLKS);

    // Longest frame is opcode plus three row address bytes
    localparam int MAX_FRAME_BYTES = 4;
    localparam int FRAME_CNT_W     = $clog2(MAX_FRAME_BYTES + 1);

    // SPI engine states
    localparam int         ENG_ST_W  = 2;
    localparam logic [1:0] ENG_IDLE  = 2'd0;   // CS high, waiting for first byte
    localparam logic [1:0] ENG_SHIFT = 2'd1;   // Bits moving on MOSI and MISO
    localparam logic [1:0] ENG_TAIL  = 2'd2;   // Final SCLK high half period
    localparam logic [1:0] ENG_GAP   = 2'd3;   // CS high, counting the gap

    // Host address/data word
    // Row commands send it MSB first, feature commands use the low two bytes
    typedef union packed {
        logic [23:0] row;
        struct packed {
            logic [7:0] rsvd;   // Not sent
            logic [7:0] addr;   // Feature register address
            logic [7:0] data;   // SET_FEATURE payload
        } feat;
    } addr_word_u;

endpackage

`default_nettype wire

/* common/cmd_cfg_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Latched command from the register block to the byte sequencer
interface cmd_cfg_if import nand_cmd_pkg::*; ();

    logic [7:0]             opcode;
    addr_word_u             addr;
    logic [FRAME_CNT_W-1:0] num_bytes;  // Frame length decoded from opcode
    logic                   start;      // One cycle, frame may begin
    logic                   done;       // One cycle, frame and gap finished

    modport reg_side (
        output opcode, addr, num_bytes, start,
        input  done
    );

    modport seq_side (
        input  opcode, addr, num_bytes, start,
        output done
    );

endinterface

`default_nettype wire

/* common/spi_byte_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Byte link between the sequencer and the SPI engine
// A byte moves when tx_valid and tx_ready are both high
interface spi_byte_if;

    logic [7:0] tx_byte;
    logic       tx_valid;       // One cycle, only while tx_ready
    logic       tx_last;        // Byte closes the frame
    logic       tx_ready;       // Engine can take a byte
    logic [7:0] rx_byte;
    logic       rx_valid;       // One cycle per received byte
    logic       frame_done;     // One cycle after CS gap

    modport seq_side (
        output tx_byte, tx_valid, tx_last,
        input  tx_ready, rx_byte, rx_valid, frame_done
    );

    modport eng_side (
        input  tx_byte, tx_valid, tx_last,
        output tx_ready, rx_byte, rx_valid, frame_done
    );

endinterface

`default_nettype wire

/* hdl/nand_cmd_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module nand_cmd_reg import nand_cmd_pkg::*; (
    input  wire logic        i_Clk,
    input  wire logic        i_Rst_L,
    input  wire logic [7:0]  i_Command,
    input  wire logic        i_CM_DV,
    input  wire logic [23:0] i_Addr_Data,
    output logic             o_CM_Ready,
    cmd_cfg_if.reg_side      cfg
);

    logic                   r_busy;         // Command in flight until done
    logic                   r_start;
    logic [7:0]             r_opcode;
    addr_word_u             r_addr;
    logic [FRAME_CNT_W-1:0] w_num_bytes;
    logic                   w_accept;

    // Strobes while busy are dropped
    assign w_accept   = i_CM_DV & ~r_busy;
    // Ready drops in the strobe cycle itself
    assign o_CM_Ready = ~r_busy & ~i_CM_DV;

    always_ff @(posedge i_Clk or negedge i_Rst_L) begin
        if (!i_Rst_L) begin
            r_busy  <= 1'b0;
            r_start <= 1'b0;
        end else begin
            r_start <= w_accept;            // Start one cycle after the strobe
            if (w_accept) begin
                r_busy <= 1'b1;
            end else if (cfg.done) begin
                r_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_Clk) begin
        if (w_accept) begin
            r_opcode <= i_Command;
            r_addr   <= i_Addr_Data;
        end
    end

    // Frame length per opcode
    always_comb begin
        case (r_opcode)
            OP_GET_FEATURE, OP_SET_FEATURE:
                w_num_bytes = FRAME_CNT_W'(3);
            OP_PAGE_READ, OP_PROG_EXEC, OP_BLOCK_ERASE:
                w_num_bytes = FRAME_CNT_W'(4);
            default:
                w_num_bytes = FRAME_CNT_W'(1);  // One-byte commands and unknown opcodes
        endcase
    end

    assign cfg.opcode    = r_opcode;
    assign cfg.addr      = r_addr;
    assign cfg.num_bytes = w_num_bytes;
    assign cfg.start     = r_start;

    // A new frame only starts once the previous one has released busy
    a_start_not_busy: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
        cfg.start |-> !$past(r_busy));

endmodule

`default_nettype wire

/* hdl/nand_byte_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module nand_byte_seq import nand_cmd_pkg::*; (
    input  wire logic    i_Clk,
    input  wire logic    i_Rst_L,
    cmd_cfg_if.seq_side  cfg,
    spi_byte_if.seq_side spi,
    output logic [7:0]   o_RX_Feature_Byte,
    output logic         o_RX_Feature_DV
);

    logic [FRAME_CNT_W-1:0] r_tx_idx;       // Next byte to queue
    logic [FRAME_CNT_W-1:0] r_rx_idx;       // Next byte to come back
    logic                   r_sending;      // More bytes left in this frame
    logic                   r_in_frame;
    logic                   r_tx_valid;
    logic                   r_tx_last;
    logic [7:0]             r_tx_byte;
    logic                   r_done;
    logic                   w_issue;
    logic                   w_last_idx;
    logic                   w_feat_hit;
    logic [7:0]             w_byte;

    // Queue a byte whenever the engine has room
    assign w_issue    = (cfg.start | r_sending) & spi.tx_ready & ~r_tx_valid;
    assign w_last_idx = (r_tx_idx == cfg.num_bytes - FRAME_CNT_W'(1));
    // Third received byte of GET_FEATURE is the register value
    assign w_feat_hit = spi.rx_valid & (cfg.opcode == OP_GET_FEATURE)
                      & (r_rx_idx == FRAME_CNT_W'(2));

    // Transmit byte by index
    always_comb begin
        w_byte = 8'h00;
        if (r_tx_idx == '0) begin
            w_byte = cfg.opcode;
        end else begin
            case (cfg.opcode)
                OP_GET_FEATURE:
                    w_byte = (r_tx_idx == FRAME_CNT_W'(1)) ? cfg.addr.feat.addr : 8'h00;
                OP_SET_FEATURE:
                    w_byte = (r_tx_idx == FRAME_CNT_W'(1)) ? cfg.addr.feat.addr
                                                           : cfg.addr.feat.data;
                OP_PAGE_READ, OP_PROG_EXEC, OP_BLOCK_ERASE: begin
                    case (r_tx_idx)
                        FRAME_CNT_W'(1): w_byte = cfg.addr.row[23:16];  // Row high
                        FRAME_CNT_W'(2): w_byte = cfg.addr.row[15:8];
                        default:         w_byte = cfg.addr.row[7:0];    // Row low
                    endcase
                end
                default: w_byte = 8'h00;
            endcase
        end
    end

    always_ff @(posedge i_Clk or negedge i_Rst_L) begin
        if (!i_Rst_L) begin
            r_tx_idx        <= '0;
            r_rx_idx        <= '0;
            r_sending       <= 1'b0;
            r_in_frame      <= 1'b0;
            r_tx_valid      <= 1'b0;
            r_tx_last       <= 1'b0;
            r_done          <= 1'b0;
            o_RX_Feature_DV <= 1'b0;
        end else begin
            r_tx_valid      <= w_issue;
            r_done          <= spi.frame_done & r_in_frame;
            o_RX_Feature_DV <= w_feat_hit;
            if (w_issue) begin
                r_tx_last <= w_last_idx;
                r_sending <= ~w_last_idx;
                r_tx_idx  <= w_last_idx ? '0 : r_tx_idx + FRAME_CNT_W'(1);
            end
            if (cfg.start) begin
                r_in_frame <= 1'b1;
                r_rx_idx   <= '0;
            end else if (spi.frame_done) begin
                r_in_frame <= 1'b0;
            end else if (spi.rx_valid) begin
                r_rx_idx <= r_rx_idx + FRAME_CNT_W'(1);
            end
        end
    end

    always_ff @(posedge i_Clk) begin
        if (w_issue)    r_tx_byte         <= w_byte;
        if (w_feat_hit) o_RX_Feature_Byte <= spi.rx_byte;
    end

    assign spi.tx_byte  = r_tx_byte;
    assign spi.tx_valid = r_tx_valid;
    assign spi.tx_last  = r_tx_last;
    assign cfg.done     = r_done;

    // Engine must still be ready when the registered valid arrives
    a_valid_with_ready: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
        spi.tx_valid |-> spi.tx_ready);

endmodule

`default_nettype wire

/* spi_master/spi_byte_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_byte_engine import nand_cmd_pkg::*; (
    input  wire logic    i_Clk,
    input  wire logic    i_Rst_L,
    spi_byte_if.eng_side spi,
    output logic         o_SPI_Clk,
    output logic         o_SPI_MOSI,
    output logic         o_SPI_CS_n,
    input  wire logic    i_SPI_MISO
);

    logic [ENG_ST_W-1:0]   r_state;
    logic [HALF_CNT_W-1:0] r_half_cnt;     // Clocks inside a half bit
    logic [3:0]            r_edge_cnt;     // Even is falling, odd is rising
    logic [GAP_CNT_W-1:0]  r_gap_cnt;
    logic                  r_tx_ready;
    logic                  r_last;         // Byte in the shifter ends the frame
    logic                  r_pend;         // Next byte held for the byte boundary
    logic                  r_pend_last;
    logic                  r_rx_valid;
    logic                  r_frame_done;
    logic [7:0]            r_tx_shift;
    logic [7:0]            r_pend_byte;
    logic [7:0]            r_rx_shift;
    logic [7:0]            r_rx_byte;
    logic                  w_accept;
    logic                  w_tick;
    logic                  w_edge;
    logic                  w_fall;
    logic                  w_rise;
    logic                  w_byte_end;
    logic                  w_has_next;

    assign w_accept   = spi.tx_valid & r_tx_ready;
    assign w_tick     = (r_half_cnt == HALF_CNT_W'(CLKS_PER_HALF_BIT - 1));
    assign w_edge     = (r_state == ENG_SHIFT) & w_tick;
    assign w_fall     = w_edge & ~r_edge_cnt[0];            // MOSI changes
    assign w_rise     = w_edge &  r_edge_cnt[0];            // MISO sampled
    assign w_byte_end = w_rise & (r_edge_cnt == 4'hF);
    assign w_has_next = r_pend | w_accept;                  // Byte taken on the boundary counts

    always_ff @(posedge i_Clk or negedge i_Rst_L) begin
        if (!i_Rst_L) begin
            r_state      <= ENG_IDLE;
            r_half_cnt   <= '0;
            r_edge_cnt   <= '0;
            r_gap_cnt    <= '0;
            r_tx_ready   <= 1'b1;
            r_last       <= 1'b0;
            r_pend       <= 1'b0;
            r_pend_last  <= 1'b0;
            r_rx_valid   <= 1'b0;
            r_frame_done <= 1'b0;
            o_SPI_Clk    <= 1'b1;       // Mode 3 idles high
            o_SPI_CS_n   <= 1'b1;
            o_SPI_MOSI   <= 1'b1;
        end else begin
            r_rx_valid   <= 1'b0;
            r_frame_done <= 1'b0;
            case (r_state)
                ENG_IDLE: begin
                    if (w_accept) begin
                        o_SPI_CS_n <= 1'b0;             // CS falls next cycle
                        r_state    <= ENG_SHIFT;
                        r_half_cnt <= '0;
                        r_edge_cnt <= '0;
                        r_last     <= spi.tx_last;
                        r_tx_ready <= 1'b0;
                    end
                end
                ENG_SHIFT: begin
                    r_half_cnt <= w_tick ? '0 : r_half_cnt + HALF_CNT_W'(1);
                    r_tx_ready <= ~r_last & ~r_pend;    // Room for one queued byte
                    if (w_accept) begin
                        r_pend      <= 1'b1;
                        r_pend_last <= spi.tx_last;
                        r_tx_ready  <= 1'b0;
                    end
                    if (w_fall) begin
                        o_SPI_Clk  <= 1'b0;
                        o_SPI_MOSI <= r_tx_shift[~r_edge_cnt[3:1]];  // MSB first
                    end
                    if (w_rise) o_SPI_Clk <= 1'b1;
                    if (w_edge) r_edge_cnt <= r_edge_cnt + 4'd1;
                    if (w_byte_end) begin
                        r_rx_valid <= 1'b1;
                        r_tx_ready <= 1'b0;
                        if (w_has_next) begin
                            r_last <= r_pend ? r_pend_last : spi.tx_last;
                            r_pend <= 1'b0;             // Keep CS low, next byte
                        end else begin
                            r_state <= ENG_TAIL;        // End of frame
                        end
                    end
                end
                ENG_TAIL: begin
                    r_half_cnt <= r_half_cnt + HALF_CNT_W'(1);
                    if (w_tick) begin
                        o_SPI_CS_n <= 1'b1;
                        r_state    <= ENG_GAP;
                        r_gap_cnt  <= '0;
                        r_half_cnt <= '0;
                    end
                end
                default: begin  // ENG_GAP
                    r_gap_cnt <= r_gap_cnt + GAP_CNT_W'(1);
                    if (r_gap_cnt == GAP_CNT_W'(CS_GAP_CLKS - 1)) begin
                        r_frame_done <= 1'b1;
                        r_tx_ready   <= 1'b1;
                        r_state      <= ENG_IDLE;
                    end
                end
            endcase
        end
    end

    // Shift data
    always_ff @(posedge i_Clk) begin
        if (w_accept && r_state == ENG_IDLE) r_tx_shift  <= spi.tx_byte;
        if (w_accept && r_state != ENG_IDLE) r_pend_byte <= spi.tx_byte;
        if (w_byte_end && w_has_next) begin
            r_tx_shift <= r_pend ? r_pend_byte : spi.tx_byte;
        end
        if (w_rise)     r_rx_shift <= {r_rx_shift[6:0], i_SPI_MISO};
        if (w_byte_end) r_rx_byte  <= {r_rx_shift[6:0], i_SPI_MISO};
    end

    assign spi.tx_ready   = r_tx_ready;
    assign spi.rx_byte    = r_rx_byte;
    assign spi.rx_valid   = r_rx_valid;
    assign spi.frame_done = r_frame_done;

    // SCLK parks high whenever the device is deselected
    a_sclk_idle_high: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
        o_SPI_CS_n |-> o_SPI_Clk);

    // Received bytes only come out inside a frame
    a_rx_in_frame: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
        spi.rx_valid |-> !o_SPI_CS_n);

endmodule

`default_nettype wire

/* hdl/nand_cmd_top.sv */
`timescale 1ns/1ps
`default_nettype none

module nand_cmd_top (
    input  wire logic        i_Clk,
    input  wire logic        i_Rst_L,

    // Host command port
    input  wire logic [7:0]  i_Command,
    input  wire logic        i_CM_DV,          // One-cycle strobe, honoured while ready
    input  wire logic [23:0] i_Addr_Data,
    output logic             o_CM_Ready,

    // SPI pins, mode 3
    output logic             o_SPI_Clk,
    output logic             o_SPI_MOSI,
    output logic             o_SPI_CS_n,
    input  wire logic        i_SPI_MISO,

    // GET_FEATURE result
    output logic [7:0]       o_RX_Feature_Byte,
    output logic             o_RX_Feature_DV
);

    cmd_cfg_if  u_cfg ();   // Register block to sequencer
    spi_byte_if u_spi ();   // Sequencer to SPI engine

    nand_cmd_reg u_cmd_reg (
        .i_Clk       (i_Clk),
        .i_Rst_L     (i_Rst_L),
        .i_Command   (i_Command),
        .i_CM_DV     (i_CM_DV),
        .i_Addr_Data (i_Addr_Data),
        .o_CM_Ready  (o_CM_Ready),
        .cfg         (u_cfg.reg_side)
    );

    nand_byte_seq u_byte_seq (
        .i_Clk             (i_Clk),
        .i_Rst_L           (i_Rst_L),
        .cfg               (u_cfg.seq_side),
        .spi               (u_spi.seq_side),
        .o_RX_Feature_Byte (o_RX_Feature_Byte),
        .o_RX_Feature_DV   (o_RX_Feature_DV)
    );

    spi_byte_engine u_spi_engine (
        .i_Clk      (i_Clk),
        .i_Rst_L    (i_Rst_L),
        .spi        (u_spi.eng_side),
        .o_SPI_Clk  (o_SPI_Clk),
        .o_SPI_MOSI (o_SPI_MOSI),
        .o_SPI_CS_n (o_SPI_CS_n),
        .i_SPI_MISO (i_SPI_MISO)
    );

endmodule

`default_nettype wire

/* dv/spi_nand_model.sv */
`timescale 1ns/1ps
`default_nettype none

// Flash side of a mode-3 SPI bus
// Captures MOSI per CS-low frame and answers with random MISO bytes
module spi_nand_model (
    input  wire logic   i_spi_clk,
    input  wire logic   i_spi_cs_n,
    input  wire logic   i_spi_mosi,
    output logic        o_spi_miso,
    output logic [31:0] o_mosi_bytes,   // Bytes of the frame, last one in [7:0]
    output logic [5:0]  o_bit_cnt,      // Bits seen in the frame
    output logic [31:0] o_miso_bytes    // Slot 0 in [31:24], slot 3 in [7:0]
);

    logic [4:0] fall_cnt;               // MISO bit slot

    initial begin : responder
        o_spi_miso   = 1'b1;
        o_mosi_bytes = '0;
        o_bit_cnt    = '0;
        o_miso_bytes = '0;
        fall_cnt     = '0;
        forever begin
            @(negedge i_spi_cs_n);
            // New frame
            o_mosi_bytes = '0;
            o_bit_cnt    = '0;
            fall_cnt     = '0;
            o_miso_bytes = $urandom;    // Fresh answer bytes per frame
            while (!i_spi_cs_n) begin
                @(i_spi_clk or i_spi_cs_n);
                if (!i_spi_cs_n && !i_spi_clk) begin
                    // Falling SCLK, present next bit
                    o_spi_miso = o_miso_bytes[5'd31 - fall_cnt];
                    fall_cnt   = fall_cnt + 5'd1;
                end else if (!i_spi_cs_n && i_spi_clk) begin
                    // Rising SCLK, MOSI is stable
                    o_mosi_bytes = {o_mosi_bytes[30:0], i_spi_mosi};
                    o_bit_cnt    = o_bit_cnt + 6'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* dv/tb_nand_cmd.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_nand_cmd import nand_cmd_pkg::*; ();

    localparam logic [31:0] SEED          = 32'he03f178e;
    localparam int          NUM_CMDS      = 200;
    localparam int          CLK_PERIOD_NS = 8;
    localparam int          WATCHDOG_NS   = NUM_CMDS * 400 * CLK_PERIOD_NS;  // 400 cycles each

    logic        clk = 1'b0;
    logic        rst_l;
    logic [7:0]  command;
    logic        cm_dv;
    logic [23:0] addr_data;
    logic        cm_ready;
    logic        spi_clk;
    logic        spi_mosi;
    logic        spi_cs_n;
    logic        spi_miso;
    logic [7:0]  rx_feat_byte;
    logic        rx_feat_dv;

    // Flash model view of the current frame
    logic [31:0] mosi_bytes;
    logic [31:0] miso_bytes;
    logic [5:0]  bit_cnt;

    // Expected frames, oldest first
    int          exp_len[$];
    logic [31:0] exp_word[$];
    logic [7:0]  exp_op[$];

    int          cmds_issued = 0;
    int          frames_seen = 0;
    int          dv_cnt      = 0;               // Feature strobes in this frame
    logic [7:0]  feat_seen   = 8'h00;
    int          cs_high_cnt = CS_GAP_CLKS;     // Nothing to space from before frame one
    logic        prev_cs_n   = 1'b1;
    logic        prev_sclk   = 1'b1;
    logic        reset_done  = 1'b0;

    nand_cmd_top DUT (
        .i_Clk             (clk),
        .i_Rst_L           (rst_l),
        .i_Command         (command),
        .i_CM_DV           (cm_dv),
        .i_Addr_Data       (addr_data),
        .o_CM_Ready        (cm_ready),
        .o_SPI_Clk         (spi_clk),
        .o_SPI_MOSI        (spi_mosi),
        .o_SPI_CS_n        (spi_cs_n),
        .i_SPI_MISO        (spi_miso),
        .o_RX_Feature_Byte (rx_feat_byte),
        .o_RX_Feature_DV   (rx_feat_dv)
    );

    spi_nand_model u_flash (
        .i_spi_clk    (spi_clk),
        .i_spi_cs_n   (spi_cs_n),
        .i_spi_mosi   (spi_mosi),
        .o_spi_miso   (spi_miso),
        .o_mosi_bytes (mosi_bytes),
        .o_bit_cnt    (bit_cnt),
        .o_miso_bytes (miso_bytes)
    );

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s (got %0h, expected %0h)", $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    // Frame length by opcode
    function automatic int frame_len(input logic [7:0] op);
        case (op)
            OP_GET_FEATURE, OP_SET_FEATURE:             return 3;
            OP_PAGE_READ, OP_PROG_EXEC, OP_BLOCK_ERASE: return 4;
            default:                                    return 1;
        endcase
    endfunction

    // MOSI bytes right aligned, first byte sent is the highest one
    function automatic logic [31:0] frame_word(input logic [7:0] op, input logic [23:0] ad);
        case (op)
            OP_GET_FEATURE:                             return {8'h00, op, ad[15:8], 8'h00};
            OP_SET_FEATURE:                             return {8'h00, op, ad[15:8], ad[7:0]};
            OP_PAGE_READ, OP_PROG_EXEC, OP_BLOCK_ERASE: return {op, ad};
            default:                                    return {24'h0, op};
        endcase
    endfunction

    function automatic logic [7:0] pick_opcode(input int sel);
        case (sel)
            0:       return OP_RESET;
            1:       return OP_WRITE_ENABLE;
            2:       return OP_WRITE_DISABLE;
            3:       return OP_GET_FEATURE;
            4:       return OP_SET_FEATURE;
            5:       return OP_PAGE_READ;
            6:       return OP_PROG_EXEC;
            7:       return OP_BLOCK_ERASE;
            default: return 8'($urandom);   // Mostly unknown values
        endcase
    endfunction

    task automatic wait_ready();
        while (!cm_ready) @(negedge clk);
    endtask

    // One accepted strobe, sometimes followed by a strobe while busy
    task automatic issue_cmd(input logic [7:0] op, input logic [23:0] ad);
        int idle;
        command   = op;
        addr_data = ad;
        cm_dv     = 1'b1;
        exp_len.push_back(frame_len(op));
        exp_word.push_back(frame_word(op, ad));
        exp_op.push_back(op);
        cmds_issued++;
        @(negedge clk);
        cm_dv = 1'b0;
        @(negedge clk);
        check_eq(32'(cm_ready), 0, "ready high after an accepted strobe");
        if ($urandom % 4 == 0) begin
            idle = 1 + int'($urandom % 20);
            repeat (idle) @(negedge clk);
            check_eq(32'(cm_ready), 0, "ready high while a frame is running");
            command   = pick_opcode(int'($urandom % 10));
            addr_data = 24'($urandom);
            cm_dv     = 1'b1;               // Must be dropped
            @(negedge clk);
            cm_dv = 1'b0;
        end
    endtask

    task automatic check_frame();
        int          len;
        logic [31:0] word;
        logic [7:0]  op;
        check_eq(32'(exp_len.size() > 0), 1, "frame on the bus with no command pending");
        len  = exp_len.pop_front();
        word = exp_word.pop_front();
        op   = exp_op.pop_front();
        check_eq(32'(bit_cnt), 32'(8 * len), $sformatf("bit count for opcode %02h", op));
        check_eq(mosi_bytes, word, $sformatf("MOSI bytes for opcode %02h", op));
        if (op == OP_GET_FEATURE) begin
            check_eq(dv_cnt, 1, "feature strobes in a GET_FEATURE frame");
            check_eq(32'(feat_seen), 32'(miso_bytes[15:8]), "feature byte vs MISO slot 2");
        end else begin
            check_eq(dv_cnt, 0, $sformatf("feature strobe for opcode %02h", op));
        end
        dv_cnt = 0;
        frames_seen++;
    endtask

    initial begin : stimulus
        int n;
        rst_l     = 1'b0;
        command   = 8'h00;
        cm_dv     = 1'b0;
        addr_data = 24'h0;
        void'($urandom(SEED));
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_l = 1'b1;
        @(negedge clk);
        reset_done = 1'b1;
        check_eq(32'(cm_ready), 1, "ready after reset");
        check_eq(32'(spi_cs_n), 1, "CS after reset");
        check_eq(32'(spi_clk), 1, "SCLK after reset");
        check_eq(32'(rx_feat_dv), 0, "feature strobe after reset");
        for (n = 0; n < NUM_CMDS; n++) begin
            wait_ready();
            check_eq(frames_seen, cmds_issued, "ready before the frame finished");
            issue_cmd(pick_opcode(int'($urandom % 10)), 24'($urandom));
        end
        wait_ready();
        repeat (4) @(negedge clk);
        if (frames_seen == cmds_issued && exp_len.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("Frames seen %0d, commands issued %0d", frames_seen, cmds_issued);
            $display("ERRORS FOUND");
            $fatal(1, "Frame count does not match command count");
        end
    end

    // Bus checks, sampled away from the active edge
    always @(negedge clk) begin : bus_monitor
        if (reset_done) begin
            if (spi_clk != prev_sclk) begin
                check_eq(32'(spi_cs_n), 0, "SCLK toggled while CS high");
            end
            if (spi_cs_n) begin
                check_eq(32'(spi_clk), 1, "SCLK not parked high while CS high");
            end else begin
                check_eq(32'(cm_ready), 0, "ready high during a frame");
            end
            if (rx_feat_dv) begin
                dv_cnt++;
                feat_seen = rx_feat_byte;
            end
            if (prev_cs_n && !spi_cs_n) begin
                check_eq(32'(cs_high_cnt >= CS_GAP_CLKS), 1, "CS gap between frames too short");
            end
            if (!prev_cs_n && spi_cs_n) check_frame();       // Frame just closed
            cs_high_cnt = spi_cs_n ? cs_high_cnt + 1 : 0;
        end
        prev_sclk = spi_clk;
        prev_cs_n = spi_cs_n;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

/* compile.f */
common/nand_cmd_pkg.sv
common/cmd_cfg_if.sv
common/spi_byte_if.sv
hdl/nand_cmd_reg.sv
hdl/nand_byte_seq.sv
spi_master/spi_byte_engine.sv
hdl/nand_cmd_top.sv
dv/spi_nand_model.sv
dv/tb_nand_cmd.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench and DUT with Verilator, then run the simulation
# Exit status is non-zero on a build error or a failing run

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_nand_cmd \
    -f compile.f \
    && ./obj_dir/Vtb_nand_cmd \
    && echo "Simulation finished cleanly" \
    || { echo "Simulation failed"; exit 1; }
